// ==== design/frame_stream_cfg.svh ====
// frame stream configuration
`ifndef FRAME_STREAM_CFG_SVH
`define FRAME_STREAM_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FS_WORD_WIDTH 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buffer and summary queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buffer depth and the initial credit count are both 2**FS_BUF_ADDR_WIDTH.
`define FS_BUF_ADDR_WIDTH 4

// 0 gives a 1 cycle read latency, 1 adds the RAM output register.
`define FS_BUF_OUTPUT_REG 0

`define FS_RES_DEPTH 4

`endif

// ==== design/frame_pkg.sv ====
// frame stream types
`include "frame_stream_cfg.svh"

package frame_pkg;

    // header word layout, tag in the high byte and seq in the low half.
    typedef struct packed {
        logic [7:0]  tag;
        logic [7:0]  len; // payload words that follow, 0 is legal.
        logic [15:0] seq;
    } frame_hdr_t;

    // one stream word. the first word of a frame is read through hdr,
    // every word after it through data.
    typedef union packed {
        frame_hdr_t                 hdr;
        logic [`FS_WORD_WIDTH-1:0]  data;
    } frame_word_u;

endpackage

// ==== design/block_ram_sdp.sv ====
// simple dual-port block RAM
`timescale 1ns/10ps

module block_ram_sdp #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10,
    parameter int OUTPUT_REG = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  write_enable,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0] write_data,

    input  logic                  read_enable,
    input  logic                  read_output_enable,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output logic [DATA_WIDTH-1:0] read_data
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [DATA_WIDTH-1:0] read_stage; // first read register, inside the RAM primitive.

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
        if (read_enable) begin
            read_stage <= mem[read_addr];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // optional output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    generate
        if (OUTPUT_REG != 0) begin : g_out_reg
            always_ff @(posedge clk) begin
                if (rst) begin
                    read_data <= '0;
                end else if (read_output_enable) begin
                    read_data <= read_stage;
                end
            end
        end else begin : g_no_out_reg
            assign read_data = read_stage;
        end
    endgenerate

endmodule

// ==== design/frame_stamper.sv ====
// frame stamper
// tracks frame boundaries, stamps sequence numbers and spends credits.
`timescale 1ns/10ps
`include "frame_stream_cfg.svh"

module frame_stamper
    import frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        src_valid,
    input  frame_word_u src_word,
    output logic        src_ready,

    output logic        push,
    output frame_word_u push_word,
    input  logic        credit
);

    localparam int BUF_DEPTH = 1 << `FS_BUF_ADDR_WIDTH;
    localparam int CNT_W     = `FS_BUF_ADDR_WIDTH + 1;

    logic [CNT_W-1:0] credit_cnt;
    logic [7:0]       rem_cnt;   // payload words left in the current frame.
    logic [15:0]      frame_cnt;
    logic             is_hdr;
    logic             accept;
    frame_word_u      stamped;

    // a push already in flight has not been taken off credit_cnt yet.
    assign src_ready = (credit_cnt > CNT_W'(push));
    assign accept    = src_valid && src_ready;
    assign is_hdr    = (rem_cnt == 8'd0);

    always_comb begin
        stamped = src_word;
        if (is_hdr) begin
            stamped.hdr.seq = frame_cnt; // the source's own seq is dropped.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            push       <= 1'b0;
            credit_cnt <= CNT_W'(BUF_DEPTH);
            rem_cnt    <= '0;
            frame_cnt  <= '0;
        end else begin
            push       <= accept;
            credit_cnt <= credit_cnt - CNT_W'(push) + CNT_W'(credit);
            if (accept) begin
                if (is_hdr) begin
                    rem_cnt   <= src_word.hdr.len;
                    frame_cnt <= frame_cnt + 16'd1; // wraps after 65535.
                end else begin
                    rem_cnt <= rem_cnt - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_word <= stamped;
        end
    end

    // credits come back from the buffer, so the count must stay bounded.
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CNT_W'(BUF_DEPTH));

    a_push_credit: assert property (@(posedge clk) disable iff (rst)
        push |-> (credit_cnt != '0));

endmodule

// ==== design/credit_buffer.sv ====
// credit buffer
// ring buffer over block RAM with fixed read latency and credit return.
`timescale 1ns/10ps
`include "frame_stream_cfg.svh"

module credit_buffer
    import frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        push,
    input  frame_word_u push_word,
    output logic        credit,

    input  logic        hold,
    output logic        out_valid,
    output frame_word_u out_word
);

    localparam int ADDR_W    = `FS_BUF_ADDR_WIDTH;
    localparam int BUF_DEPTH = 1 << ADDR_W;
    localparam int BUF_LAT   = 1 + `FS_BUF_OUTPUT_REG;

    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [ADDR_W:0]    occupancy;
    logic               pop;
    logic [BUF_LAT-1:0] vld_pipe; // bit i set means a read is i+1 cycles old.

    assign pop       = (occupancy != '0) && !hold;
    assign credit    = pop; // each word read frees one slot.
    assign out_valid = vld_pipe[BUF_LAT-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            occupancy <= occupancy + (ADDR_W + 1)'(push) - (ADDR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= pop;
            for (int i = 1; i < BUF_LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // a word pushed on one edge is readable from the next cycle on,
    // and the empty check keeps a pop off the slot being written.
    block_ram_sdp #(
        .DATA_WIDTH (`FS_WORD_WIDTH),
        .ADDR_WIDTH (ADDR_W),
        .OUTPUT_REG (`FS_BUF_OUTPUT_REG)
    ) ram_i (
        .clk                (clk),
        .rst                (rst),
        .write_enable       (push),
        .write_addr         (wr_ptr),
        .write_data         (push_word),
        .read_enable        (pop),
        .read_output_enable (vld_pipe[0]),
        .read_addr          (rd_ptr),
        .read_data          (out_word)
    );

    // the producer's credit count is what keeps this from happening.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (occupancy != (ADDR_W + 1)'(BUF_DEPTH)));

endmodule

// ==== design/frame_summarizer.sv ====
// frame summarizer
// decodes words, accumulates per-frame summaries and queues them.
`timescale 1ns/10ps
`include "frame_stream_cfg.svh"

module frame_summarizer
    import frame_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      out_valid,
    input  frame_word_u               out_word,
    output logic                      hold,

    output logic                      res_valid,
    output logic [7:0]                res_tag,
    output logic [7:0]                res_len,
    output logic [15:0]               res_seq,
    output logic [`FS_WORD_WIDTH-1:0] res_sum,
    input  logic                      sink_ready
);

    localparam int W         = `FS_WORD_WIDTH;
    localparam int BUF_LAT   = 1 + `FS_BUF_OUTPUT_REG;
    localparam int RES_DEPTH = `FS_RES_DEPTH;
    localparam int PTR_W     = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int CNT_W     = $clog2(RES_DEPTH + 1);

    logic [7:0]       rem_cnt; // payload words still expected.
    logic             is_hdr;
    logic             done;
    frame_hdr_t       cur_hdr;
    logic [W-1:0]     acc;
    frame_hdr_t       done_hdr;
    logic [W-1:0]     done_sum;

    frame_hdr_t       q_hdr [RES_DEPTH];
    logic [W-1:0]     q_sum [RES_DEPTH];
    logic [PTR_W-1:0] q_wr_ptr;
    logic [PTR_W-1:0] q_rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_hdr = (rem_cnt == 8'd0);

    always_comb begin
        done_hdr = is_hdr ? out_word.hdr : cur_hdr;
        done_sum = is_hdr ? '0 : (acc ^ out_word.data);
        // an empty frame completes on its header alone.
        done = out_valid && (is_hdr ? (out_word.hdr.len == 8'd0) : (rem_cnt == 8'd1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_cnt <= '0;
        end else if (out_valid) begin
            rem_cnt <= is_hdr ? out_word.hdr.len : (rem_cnt - 8'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (out_valid) begin
            if (is_hdr) begin
                cur_hdr <= out_word.hdr;
                acc     <= '0;
            end else begin
                acc <= acc ^ out_word.data;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // summary queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign q_pop     = res_valid && sink_ready;
    assign res_valid = (q_count != '0);
    assign res_tag   = q_hdr[q_rd_ptr].tag;
    assign res_len   = q_hdr[q_rd_ptr].len;
    assign res_seq   = q_hdr[q_rd_ptr].seq;
    assign res_sum   = q_sum[q_rd_ptr];

    // every word still in the buffer pipeline may close a frame, so stop
    // popping while the free entries could not take them all.
    assign hold = (q_count >= CNT_W'(RES_DEPTH - BUF_LAT));

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (done) begin
                q_wr_ptr <= next_ptr(q_wr_ptr);
            end
            if (q_pop) begin
                q_rd_ptr <= next_ptr(q_rd_ptr);
            end
            q_count <= q_count + CNT_W'(done) - CNT_W'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            q_hdr[q_wr_ptr] <= done_hdr;
            q_sum[q_wr_ptr] <= done_sum;
        end
    end

    // relies on hold reaching the buffer early enough for its read latency.
    a_no_lost_summary: assert property (@(posedge clk) disable iff (rst)
        done |-> (q_count != CNT_W'(RES_DEPTH)));

endmodule

// ==== design/frame_stream_top.sv ====
// frame stream top level
`timescale 1ns/10ps
`include "frame_stream_cfg.svh"

module frame_stream_top
    import frame_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      src_valid,
    input  frame_word_u               src_word,
    output logic                      src_ready,

    output logic                      res_valid,
    output logic [7:0]                res_tag,
    output logic [7:0]                res_len,
    output logic [15:0]               res_seq,
    output logic [`FS_WORD_WIDTH-1:0] res_sum,
    input  logic                      sink_ready
);

    logic        push;
    frame_word_u push_word;
    logic        credit;
    logic        hold;
    logic        out_valid;
    frame_word_u out_word;

    frame_stamper stamper_i (
        .clk       (clk),
        .rst       (rst),
        .src_valid (src_valid),
        .src_word  (src_word),
        .src_ready (src_ready),
        .push      (push),
        .push_word (push_word),
        .credit    (credit)
    );

    credit_buffer buffer_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_word (push_word),
        .credit    (credit),
        .hold      (hold),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    frame_summarizer summarizer_i (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .hold       (hold),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_len    (res_len),
        .res_seq    (res_seq),
        .res_sum    (res_sum),
        .sink_ready (sink_ready)
    );

endmodule

// ==== test/frame_stream_tb.sv ====
// frame stream testbench
`timescale 1ns/10ps
`include "frame_stream_cfg.svh"

module frame_stream_tb
    import frame_pkg::*;
();

    localparam int STALL_CYCLES = 60; // long enough to drain all credits.

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      src_valid;
    frame_word_u               src_word;
    logic                      src_ready;
    logic                      sink_ready;
    logic                      res_valid;
    logic [7:0]                res_tag;
    logic [7:0]                res_len;
    logic [15:0]               res_seq;
    logic [`FS_WORD_WIDTH-1:0] res_sum;

    frame_word_u stim_words [$];
    frame_hdr_t  exp_hdr [$];
    frame_word_u exp_sum [$];

    int     n_frames = 0;
    int     match_cnt = 0;
    int     cycle_cnt = 0;
    int     timeout_limit = 0;
    integer seed;
    logic   rst_done = 1'b0;
    logic   stall_active = 1'b0;
    logic   saw_ready_low = 1'b0;

    frame_stream_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_word   (src_word),
        .src_ready  (src_ready),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_len    (res_len),
        .res_seq    (res_seq),
        .res_sum    (res_sum),
        .sink_ready (sink_ready)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_hdr(input frame_hdr_t got, input frame_hdr_t exp, input int idx);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: frame %0d tag/len/seq %h/%h/%h, expected %h/%h/%h",
                     $time, idx, got.tag, got.len, got.seq, exp.tag, exp.len, exp.seq);
            fail_run();
        end
    endtask

    task automatic check_sum(input frame_word_u got, input frame_word_u exp, input int idx);
        if (got.data !== exp.data) begin
            $display("CHECK FAILED at %0t ns: frame %0d payload xor %h, expected %h",
                     $time, idx, got.data, exp.data);
            fail_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic load_tests();
        int               fd;
        int               code;
        logic [31:0]      raw;
        logic [7:0]       e_tag;
        logic [7:0]       e_len;
        logic [15:0]      e_seq;
        logic [31:0]      e_sum;
        logic [8*200-1:0] line;
        frame_word_u      word;

        fd = $fopen("test/frame_stream_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/frame_stream_tests.txt");
            fail_run();
        end
        code = $fgets(line, fd); // two lines of column notes.
        code = $fgets(line, fd);
        while ($fscanf(fd, "%h", raw) == 1) begin
            word.data = raw;
            stim_words.push_back(word);
            for (int j = 0; j < int'(word.hdr.len); j++) begin
                code = $fscanf(fd, "%h", raw);
                if (code != 1) begin
                    $display("frame %0d in the data file ends before its payload", n_frames);
                    fail_run();
                end
                stim_words.push_back(frame_word_u'(raw));
            end
            code = $fscanf(fd, "%h %h %h %h", e_tag, e_len, e_seq, e_sum);
            if (code != 4) begin
                $display("frame %0d in the data file has no expected summary", n_frames);
                fail_run();
            end
            exp_hdr.push_back({e_tag, e_len, e_seq});
            exp_sum.push_back(frame_word_u'(e_sum));
            n_frames++;
        end
        $fclose(fd);
        timeout_limit = 20 * stim_words.size() + 200;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source and sink
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : source
        int idx;

        idx = 0;
        wait (rst_done);
        while (idx < stim_words.size()) begin
            @(negedge clk);
            src_valid = 1'b1;
            src_word  = stim_words[idx];
            @(posedge clk);
            if (src_ready) begin
                idx++; // the word went across on this edge.
            end
        end
        @(negedge clk);
        src_valid = 1'b0;
    end

    initial begin : sink
        wait (rst_done);
        stall_active = 1'b1; // sink held off while the long frame is sent.
        repeat (STALL_CYCLES) @(negedge clk);
        stall_active = 1'b0;
        forever begin
            @(negedge clk);
            sink_ready = (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        if (stall_active && src_valid && !src_ready) begin
            saw_ready_low = 1'b1;
        end
    end

    // summaries are compared in the order of the data file.
    always @(posedge clk) begin
        if (!rst && res_valid && sink_ready) begin
            if (match_cnt >= n_frames) begin
                $display("CHECK FAILED at %0t ns: summary after the last frame", $time);
                fail_run();
            end else begin
                check_hdr({res_tag, res_len, res_seq}, exp_hdr[match_cnt], match_cnt);
                check_sum(frame_word_u'(res_sum), exp_sum[match_cnt], match_cnt);
                match_cnt = match_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_done) begin
            cycle_cnt++;
            if (cycle_cnt > timeout_limit) begin
                $display("run timed out after %0d cycles with %0d of %0d summaries received",
                         cycle_cnt, match_cnt, n_frames);
                fail_run();
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst        = 1'b1;
        src_valid  = 1'b0;
        src_word   = '0;
        sink_ready = 1'b0;
        seed       = 32'hc798_750b;
        load_tests();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        rst_done = 1'b1;
        @(negedge clk);
        check_bit(res_valid, 1'b0, "res_valid after reset");
        check_bit(src_ready, 1'b1, "src_ready after reset");
        wait (match_cnt == n_frames);
        repeat (20) @(posedge clk);
        check_bit(res_valid, 1'b0, "res_valid after the last summary");
        if (!saw_ready_low) begin
            $display("src_ready never fell while the sink was stalled");
            fail_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== test/frame_stream_tests.txt ====
# frame: header word (tag len seq, hex) then len payload words, may wrap lines
# summary after each frame: tag len seq xor, where seq is the frame index
1100ffff
11 00 0000 00000000
22021234 000000ff 0f0f0000
22 02 0001 0f0f00ff
3301abcd deadbeef
33 01 0002 deadbeef
44140000 00000001 00000002 00000004 00000008 00000010 00000020 00000040
00000080 00000100 00000200 00000400 00000800 00001000 00002000 00004000
00008000 00010000 00020000 00040000 00080000
44 14 0003 000fffff
55007777
55 00 0004 00000000
66030000 12345678 87654321 0f0f0f0f
66 03 0005 9a5e1a56
77000000
77 00 0006 00000000
9902beef ffff0000 0000ffff
99 02 0007 ffffffff
aa050101 11111111 22222222 44444444 88888888 10101010
aa 05 0008 efefefef
bb120000 cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d
cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d cafef00d
cafef00d 00000001
bb 12 0009 cafef00c

// ==== files.f ====
+incdir+design
design/frame_pkg.sv
design/block_ram_sdp.sv
design/frame_stamper.sv
design/credit_buffer.sv
design/frame_summarizer.sv
design/frame_stream_top.sv
test/frame_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the frame stream testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module frame_stream_tb -f files.f \
    -o frame_stream_sim > build.log 2>&1 \
    && ./obj_dir/frame_stream_sim > sim.log 2>&1
grep -q "^TEST PASS$" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
